//--- hw/srtDiv_cfg.svh
// divider sizes; mantissas carry the hidden bit, widths beyond these values are untested
`ifndef SRT_DIV_CFG_SVH
`define SRT_DIV_CFG_SVH

// mantissa width with the hidden bit
`define SRT_MANT_W 24

// biased exponent width and bias
`define SRT_EXP_W 8
`define SRT_BIAS 127

// quotient has one integer bit above these fraction bits
`define SRT_QUOT_FRAC 27

// radix-4 digits produced per division
`define SRT_ITERS 14

// residual carries 4 integer bits and 3 guard bits around the mantissa
`define SRT_RES_W 30

`endif

//--- hw/srtDivPkg.sv
// shared divider types; field order of the request and response structs is the external contract
`include "srtDiv_cfg.svh"

package srtDivPkg;

  // plain vectors with a meaning of their own
  typedef logic [`SRT_MANT_W-1:0] mantT;
  typedef logic [`SRT_EXP_W-1:0] expT;
  // computed exponent wraps modulo 2^10
  typedef logic [`SRT_EXP_W+1:0] calcExpT;
  typedef logic [$clog2(`SRT_MANT_W+1)-1:0] lzCntT;
  typedef logic [`SRT_QUOT_FRAC:0] quotT;
  typedef logic [`SRT_RES_W-1:0] residT;

  // one-hot digit, bit 3 down to bit 0 is +2 +1 -1 -2, zero when no bit set
  typedef logic [3:0] digitT;

  typedef enum logic [1:0] {
    iterIdle,
    iterRun,
    iterHold
  } iterStateT;

  typedef struct packed {
    mantT xMant;
    mantT yMant;
    expT xExp;
    expT yExp;
  } divReqT;

  typedef struct packed {
    mantT xNorm;
    mantT yNorm;
    calcExpT exp;
  } prepT;

  // residual still in carry-save form, divisor at residual scale
  typedef struct packed {
    quotT quot;
    quotT quotM;
    residT resSum;
    residT resCarry;
    residT divisor;
    calcExpT exp;
  } rawResT;

  typedef struct packed {
    quotT quot;
    calcExpT exp;
    logic sticky;
  } divRespT;

endpackage

//--- hw/quotSelect.sv
// digit selection table; assumes divisor in [1,2) with its leading one at residual bit 26
`timescale 1ns/1ns
`include "srtDiv_cfg.svh"

module quotSelect (
  input  srtDivPkg::residT divisor,
  input  srtDivPkg::residT resSum,
  input  srtDivPkg::residT resCarry,
  output srtDivPkg::digitT digit
);
  import srtDivPkg::*;

  logic [7:0] topSum;
  logic signed [6:0] est;
  logic [2:0] dIdx;
  logic [27:0] thr;
  logic signed [6:0] mP2;
  logic signed [6:0] mP1;
  logic signed [6:0] mZ;
  logic signed [6:0] mN1;

  // short add on the top bits only
  // estimate is 4 integer and 3 fraction bits, never above the true residual
  assign topSum = resSum[`SRT_RES_W-1 -: 8] + resCarry[`SRT_RES_W-1 -: 8];
  assign est = topSum[7:1];

  // three bits below the leading one pick one of eight divisor intervals
  assign dIdx = divisor[`SRT_RES_W-5 -: 3];

  // thresholds in units of 1/8, ordered +2 +1 0 -1
  // each keeps the next residual within 2/3 of the divisor
  // allowing for the 3/16 truncation error of the estimate
  always_comb begin
    case (dIdx)
      3'd0: thr = {7'd12, 7'd4, -7'd4, -7'd13};
      3'd1: thr = {7'd14, 7'd4, -7'd6, -7'd15};
      3'd2: thr = {7'd15, 7'd4, -7'd6, -7'd16};
      3'd3: thr = {7'd16, 7'd4, -7'd6, -7'd18};
      3'd4: thr = {7'd18, 7'd6, -7'd8, -7'd20};
      3'd5: thr = {7'd20, 7'd6, -7'd8, -7'd20};
      3'd6: thr = {7'd20, 7'd8, -7'd8, -7'd22};
      default: thr = {7'd24, 7'd8, -7'd8, -7'd24};
    endcase
  end

  assign mP2 = thr[27:21];
  assign mP1 = thr[20:14];
  assign mZ = thr[13:7];
  assign mN1 = thr[6:0];

  // compare top down
  always_comb begin
    if (est >= mP2) begin
      digit = 4'b1000;
    end else if (est >= mP1) begin
      digit = 4'b0100;
    end else if (est >= mZ) begin
      digit = 4'b0000;
    end else if (est >= mN1) begin
      digit = 4'b0010;
    end else begin
      digit = 4'b0001;
    end
  end

endmodule

//--- hw/otfConvert.sv
// on-the-fly quotient conversion; start and advance must not be raised together
`timescale 1ns/1ns
`include "srtDiv_cfg.svh"

module otfConvert (
  input  logic clk,
  input  logic start,
  input  logic advance,
  input  srtDivPkg::digitT digit,
  output srtDivPkg::quotT quot,
  output srtDivPkg::quotT quotM
);
  import srtDivPkg::*;

  // both words lose their top two bits on every shift
  logic [`SRT_QUOT_FRAC-2:0] qKeep;
  logic [`SRT_QUOT_FRAC-2:0] qmKeep;
  quotT quotNext;
  quotT quotMNext;

  assign qKeep = quot[`SRT_QUOT_FRAC-2:0];
  assign qmKeep = quotM[`SRT_QUOT_FRAC-2:0];

  // quotM always tracks quot minus one ulp
  // negative digits borrow from quotM so no carry ever ripples
  always_comb begin
    case (digit)
      4'b1000: begin
        quotNext = {qKeep, 2'b10};
        quotMNext = {qKeep, 2'b01};
      end
      4'b0100: begin
        quotNext = {qKeep, 2'b01};
        quotMNext = {qKeep, 2'b00};
      end
      4'b0010: begin
        quotNext = {qmKeep, 2'b11};
        quotMNext = {qmKeep, 2'b10};
      end
      4'b0001: begin
        quotNext = {qmKeep, 2'b10};
        quotMNext = {qmKeep, 2'b01};
      end
      default: begin
        quotNext = {qKeep, 2'b00};
        quotMNext = {qmKeep, 2'b11};
      end
    endcase
  end

  // zero and minus one at the start of a division
  always_ff @(posedge clk) begin
    if (start) begin
      quot <= '0;
      quotM <= '1;
    end else if (advance) begin
      quot <= quotNext;
      quotM <= quotMNext;
    end
  end

endmodule

//--- hw/operandPrep.sv
// input stage; a zero dividend is legal but a zero divisor must never be sent
`timescale 1ns/1ns
`include "srtDiv_cfg.svh"

module operandPrep (
  input  logic clk,
  input  logic rst,
  input  srtDivPkg::divReqT req,
  input  logic reqValid,
  output logic reqReady,
  output srtDivPkg::prepT prep,
  output logic prepValid,
  input  logic prepReady
);
  import srtDivPkg::*;

  lzCntT xLz;
  lzCntT yLz;
  mantT xNorm;
  mantT yNorm;
  logic xZero;
  calcExpT expNext;
  logic reqFire;

  // leading zeros of a mantissa, full width when the mantissa is zero
  function automatic lzCntT countLz(input mantT m);
    lzCntT cnt;
    cnt = lzCntT'(`SRT_MANT_W);
    // highest set bit wins since it is visited last
    for (int i = 0; i < `SRT_MANT_W; i++) begin
      if (m[i]) begin
        cnt = lzCntT'(`SRT_MANT_W - 1 - i);
      end
    end
    return cnt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // normalize
  //////////////////////////////////////////////////////////////////////

  assign xLz = countLz(req.xMant);
  assign yLz = countLz(req.yMant);

  // both land in [1,2) with the hidden bit at the top
  assign xNorm = req.xMant << xLz;
  assign yNorm = req.yMant << yLz;

  assign xZero = (req.xMant == '0);

  // exponent corrected for both normalization shifts
  // zero dividend reports exponent 0
  always_comb begin
    expNext = calcExpT'(req.xExp) - calcExpT'(xLz) - calcExpT'(req.yExp);
    expNext = expNext + calcExpT'(yLz) + calcExpT'(`SRT_BIAS);
    if (xZero) begin
      expNext = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // one-entry holding register
  //////////////////////////////////////////////////////////////////////

  // free slot or slot emptying this cycle
  assign reqReady = !prepValid || prepReady;
  assign reqFire = reqValid && reqReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      prepValid <= 1'b0;
    end else if (reqFire) begin
      prepValid <= 1'b1;
    end else if (prepReady) begin
      prepValid <= 1'b0;
    end
  end

  // payload only moves on an accepted request
  always_ff @(posedge clk) begin
    if (reqFire) begin
      prep <= '{xNorm: xNorm, yNorm: yNorm, exp: expNext};
    end
  end

endmodule

//--- hw/srtIterate.sv
// radix-4 recurrence; one division at a time, inputs must be normalized with a nonzero divisor
`timescale 1ns/1ns
`include "srtDiv_cfg.svh"

module srtIterate (
  input  logic clk,
  input  logic rst,
  input  srtDivPkg::prepT prep,
  input  logic prepValid,
  output logic prepReady,
  output srtDivPkg::rawResT raw,
  output logic rawValid,
  input  logic rawReady
);
  import srtDivPkg::*;

  localparam int CntW = $clog2(`SRT_ITERS + 1);

  iterStateT state;
  logic [CntW-1:0] digitCnt;
  residT resSum;
  residT resCarry;
  residT divisor;
  calcExpT expQ;
  digitT digit;
  residT divMul;
  logic negCin;
  residT csaSum;
  residT csaMaj;
  residT csaCarry;
  logic loadEn;
  logic stepEn;
  quotT quot;
  quotT quotM;

  assign prepReady = (state == iterIdle);
  assign rawValid = (state == iterHold);
  assign loadEn = (state == iterIdle) && prepValid;
  // last run cycle has a zero count and only moves to hold
  assign stepEn = (state == iterRun) && (digitCnt != '0);

  quotSelect qSel0 (
    .divisor(divisor),
    .resSum(resSum),
    .resCarry(resCarry),
    .digit(digit)
  );

  otfConvert otf0 (
    .clk(clk),
    .start(loadEn),
    .advance(stepEn),
    .digit(digit),
    .quot(quot),
    .quotM(quotM)
  );

  //////////////////////////////////////////////////////////////////////
  // divisor multiple and carry-save step
  //////////////////////////////////////////////////////////////////////

  // positive digits subtract, so complement plus carry-in
  always_comb begin
    negCin = 1'b0;
    case (digit)
      4'b1000: begin
        divMul = ~(divisor << 1);
        negCin = 1'b1;
      end
      4'b0100: begin
        divMul = ~divisor;
        negCin = 1'b1;
      end
      4'b0010: divMul = divisor;
      4'b0001: divMul = divisor << 1;
      default: divMul = '0;
    endcase
  end

  // 3:2 compressor, carry-in slots into the free lsb of the carry word
  assign csaSum = resSum ^ resCarry ^ divMul;
  assign csaMaj = (resSum & resCarry) | (resSum & divMul) | (resCarry & divMul);
  assign csaCarry = {csaMaj[`SRT_RES_W-2:0], negCin};

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= iterIdle;
      digitCnt <= '0;
    end else begin
      case (state)
        iterIdle: begin
          if (prepValid) begin
            state <= iterRun;
            digitCnt <= CntW'(`SRT_ITERS);
          end
        end
        iterRun: begin
          if (digitCnt == '0) begin
            state <= iterHold;
          end else begin
            digitCnt <= digitCnt - 1'b1;
          end
        end
        iterHold: begin
          if (rawReady) begin
            state <= iterIdle;
          end
        end
        default: state <= iterIdle;
      endcase
    end
  end

  // registers hold 4w, so the dividend loads as 4 times x/4
  // residual keeps 3 zero guard bits at the bottom
  always_ff @(posedge clk) begin
    if (loadEn) begin
      resSum <= {3'b000, prep.xNorm, 3'b000};
      resCarry <= '0;
      divisor <= {3'b000, prep.yNorm, 3'b000};
      expQ <= prep.exp;
    end else if (stepEn) begin
      resSum <= {csaSum[`SRT_RES_W-3:0], 2'b00};
      resCarry <= {csaCarry[`SRT_RES_W-3:0], 2'b00};
    end
  end

  assign raw = '{
    quot: quot,
    quotM: quotM,
    resSum: resSum,
    resCarry: resCarry,
    divisor: divisor,
    exp: expQ
  };

endmodule

//--- hw/resultPack.sv
// output stage; quotient is truncated, sticky covers every bit below it, no rounding done
`timescale 1ns/1ns
`include "srtDiv_cfg.svh"

module resultPack (
  input  logic clk,
  input  logic rst,
  input  srtDivPkg::rawResT raw,
  input  logic rawValid,
  output logic rawReady,
  output srtDivPkg::divRespT resp,
  output logic respValid,
  input  logic respReady
);
  import srtDivPkg::*;

  residT remSum;
  logic remNeg;
  residT div2;
  residT div4;
  residT remFix;
  residT remTrial;
  quotT quotSel;
  logic lastBit;
  logic sticky;
  logic rawFire;

  //////////////////////////////////////////////////////////////////////
  // remainder resolve
  //////////////////////////////////////////////////////////////////////

  // full add of the carry-save pair gives 4 times the last residual
  assign remSum = raw.resSum + raw.resCarry;
  assign remNeg = remSum[`SRT_RES_W-1];

  assign div2 = raw.divisor << 1;
  assign div4 = raw.divisor << 2;

  // negative remainder means the digits overshot by one ulp
  assign quotSel = remNeg ? raw.quotM : raw.quot;
  assign remFix = remNeg ? (remSum + div4) : remSum;

  // digits cover x/4d, so one more radix-2 step brings back the low bit
  // that bit is set when the fixed remainder reaches half the divisor
  assign remTrial = remFix - div2;
  assign lastBit = !remTrial[`SRT_RES_W-1];

  // anything left after the final bit
  assign sticky = lastBit ? (remTrial != '0) : (remFix != '0);

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  assign rawReady = !respValid || respReady;
  assign rawFire = rawValid && rawReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      respValid <= 1'b0;
    end else if (rawFire) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // top bit of quotSel is always clear since x/4d stays below one half
  always_ff @(posedge clk) begin
    if (rawFire) begin
      resp <= '{
        quot: {quotSel[`SRT_QUOT_FRAC-1:0], lastBit},
        exp: raw.exp,
        sticky: sticky
      };
    end
  end

endmodule

//--- hw/srtDivTop.sv
// divider top; no zero divisor, no special values, up to three divisions in flight
`timescale 1ns/1ns

module srtDivTop (
  input  logic clk,
  input  logic rst,
  input  srtDivPkg::divReqT req,
  input  logic reqValid,
  output logic reqReady,
  output srtDivPkg::divRespT resp,
  output logic respValid,
  input  logic respReady
);
  import srtDivPkg::*;

  // normalized operands into the iterator
  prepT prep;
  logic prepValid;
  logic prepReady;

  // carry-save result into the output stage
  rawResT raw;
  logic rawValid;
  logic rawReady;

  operandPrep prep0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .prep(prep),
    .prepValid(prepValid),
    .prepReady(prepReady)
  );

  srtIterate iter0 (
    .clk(clk),
    .rst(rst),
    .prep(prep),
    .prepValid(prepValid),
    .prepReady(prepReady),
    .raw(raw),
    .rawValid(rawValid),
    .rawReady(rawReady)
  );

  resultPack pack0 (
    .clk(clk),
    .rst(rst),
    .raw(raw),
    .rawValid(rawValid),
    .rawReady(rawReady),
    .resp(resp),
    .respValid(respValid),
    .respReady(respReady)
  );

endmodule

//--- verif/srtDivTb.sv
// divider testbench; never sends a zero divisor, expected values come from an integer model
`timescale 1ns/1ns
`include "srtDiv_cfg.svh"

module srtDivTb;
  import srtDivPkg::*;

  // directed 4, random 200, unnormalized 25, latency 1, back-pressure 60
  localparam int NumReq = 290;
  localparam int Latency = `SRT_ITERS + 3;
  localparam int TimeoutCycles = NumReq * 40 + 500;

  logic clk;
  logic rst;
  divReqT req;
  logic reqValid;
  logic reqReady;
  divRespT resp;
  logic respValid;
  logic respReady;

  // expected responses in request order
  divRespT expQ[$];
  string nameQ[$];

  logic [31:0] stimState;
  logic [31:0] rdyState;
  logic [31:0] r1;
  logic [31:0] r2;
  logic [31:0] r3;
  divReqT rq;
  int cycle = 0;
  int lastAccept;
  logic randReady;
  logic sawStall;

  srtDivTop dut0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .resp(resp),
    .respValid(respValid),
    .respReady(respReady)
  );

  //////////////////////////////////////////////////////////////////////
  // clock, cycle count and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    reportFail("watchdog expired, responses never arrived");
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic nextRand(output logic [31:0] v);
    stimState = lcgNext(stimState);
    v = stimState;
  endtask

  // integer model: shift both mantissas up, then one wide divide
  function automatic divRespT refDiv(input divReqT r);
    logic [63:0] xn;
    logic [63:0] yn;
    logic [63:0] q;
    logic [63:0] rem;
    int xLz;
    int yLz;
    divRespT res;
    xn = 64'(r.xMant);
    yn = 64'(r.yMant);
    xLz = 0;
    yLz = 0;
    if (xn != 0) begin
      while (!xn[`SRT_MANT_W-1]) begin
        xn = xn << 1;
        xLz++;
      end
    end
    while (!yn[`SRT_MANT_W-1]) begin
      yn = yn << 1;
      yLz++;
    end
    q = (xn << `SRT_QUOT_FRAC) / yn;
    rem = (xn << `SRT_QUOT_FRAC) % yn;
    res.quot = quotT'(q);
    res.sticky = (rem != 0);
    // exponent wraps at 10 bits
    res.exp = calcExpT'(r.xExp) + calcExpT'(`SRT_BIAS) + calcExpT'(yLz);
    res.exp = res.exp - calcExpT'(r.yExp) - calcExpT'(xLz);
    if (r.xMant == '0) begin
      res.exp = '0;
    end
    return res;
  endfunction

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkQuot(input string name, input quotT expVal, input quotT actVal);
    if (actVal !== expVal) begin
      reportFail($sformatf("FAIL %s quot expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkExp(input string name, input calcExpT expVal, input calcExpT actVal);
    if (actVal !== expVal) begin
      reportFail($sformatf("FAIL %s exp expected %h actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkSticky(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      reportFail($sformatf("FAIL %s sticky expected %b actual %b", name, expVal, actVal));
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic sendReq(input divReqT r, input string name);
    expQ.push_back(refDiv(r));
    nameQ.push_back(name);
    req = r;
    reqValid = 1'b1;
    while (!reqReady) begin
      sawStall = 1'b1;
      @(negedge clk);
    end
    // handshake lands on the coming rising edge
    lastAccept = cycle + 1;
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic drain();
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // response side, ready driven and handshake judged on the same falling edge
  //////////////////////////////////////////////////////////////////////

  initial begin
    divRespT e;
    string n;
    respReady = 1'b1;
    forever begin
      @(negedge clk);
      rdyState = lcgNext(rdyState);
      // mostly low so the output register stays full and stalls the iterator
      respReady = randReady ? (rdyState[31:29] == 3'b000) : 1'b1;
      if (respValid && respReady) begin
        if (expQ.size() == 0) begin
          reportFail("a response arrived with no request outstanding");
        end
        e = expQ.pop_front();
        n = nameQ.pop_front();
        checkQuot(n, e.quot, resp.quot);
        checkExp(n, e.exp, resp.exp);
        checkSticky(n, e.sticky, resp.sticky);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    req = '0;
    reqValid = 1'b0;
    stimState = 32'h8075;
    rdyState = lcgNext(32'h8075);
    randReady = 1'b0;
    sawStall = 1'b0;
    lastAccept = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // exact quotients
    sendReq('{xMant: 24'hC00000, yMant: 24'h800000, xExp: 8'd130, yExp: 8'd127}, "dir 1.5/1.0");
    sendReq('{xMant: 24'hA5A5A5, yMant: 24'hA5A5A5, xExp: 8'd100, yExp: 8'd100}, "dir equal");
    sendReq('{xMant: 24'hFFFFFF, yMant: 24'hFFFFFF, xExp: 8'd1, yExp: 8'd254}, "dir ones");
    sendReq('{xMant: 24'hA00000, yMant: 24'h800000, xExp: 8'd254, yExp: 8'd1}, "dir 1.25/1.0");
    drain();

    for (int i = 0; i < 200; i++) begin
      nextRand(r1);
      nextRand(r2);
      nextRand(r3);
      rq.xMant = {1'b1, r1[31:9]};
      rq.yMant = {1'b1, r2[31:9]};
      rq.xExp = r3[31:24];
      rq.yExp = r3[23:16];
      sendReq(rq, "random normalized");
    end
    drain();

    // subnormal-style operands, zero dividend included
    sendReq('{xMant: 24'h000001, yMant: 24'h800000, xExp: 8'd0, yExp: 8'd127}, "unnorm tiny x");
    sendReq('{xMant: 24'h00ABCD, yMant: 24'h000300, xExp: 8'd0, yExp: 8'd0}, "unnorm both");
    sendReq('{xMant: 24'h000000, yMant: 24'hC00000, xExp: 8'd90, yExp: 8'd30}, "zero dividend");
    sendReq('{xMant: 24'h000000, yMant: 24'h000007, xExp: 8'd0, yExp: 8'd0}, "zero over tiny");
    sendReq('{xMant: 24'hFFFFFF, yMant: 24'h000001, xExp: 8'd200, yExp: 8'd0}, "unnorm tiny y");
    for (int i = 0; i < 20; i++) begin
      nextRand(r1);
      nextRand(r2);
      nextRand(r3);
      rq.xMant = {1'b1, r1[31:9]} >> (r3[15:11] % 24);
      rq.yMant = {1'b1, r2[31:9]} >> (r3[10:6] % 24);
      rq.xExp = r3[31:24];
      rq.yExp = r3[23:16];
      sendReq(rq, "random unnormalized");
    end
    drain();

    // idle unit, ready held high
    sendReq('{xMant: 24'h9ABCDE, yMant: 24'hD00001, xExp: 8'd127, yExp: 8'd127}, "latency");
    while (!respValid) begin
      @(negedge clk);
    end
    if (cycle - lastAccept != Latency) begin
      reportFail($sformatf("FAIL latency expected %0d actual %0d", Latency, cycle - lastAccept));
    end
    drain();

    // back-to-back requests against a toggling ready
    randReady = 1'b1;
    sawStall = 1'b0;
    for (int i = 0; i < 60; i++) begin
      nextRand(r1);
      nextRand(r2);
      nextRand(r3);
      rq.xMant = {1'b1, r1[31:9]} >> (r3[15:11] % 4);
      rq.yMant = {1'b1, r2[31:9]};
      rq.xExp = r3[31:24];
      rq.yExp = r3[23:16];
      sendReq(rq, "back-pressure");
    end
    drain();
    randReady = 1'b0;
    if (!sawStall) begin
      reportFail("reqReady never fell while the stages were full");
    end

    // every expected response is taken, so nothing may still be offered
    if (!respValid) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      reportFail("a response was still offered after every request was answered");
    end
  end

endmodule

//--- project.f
+incdir+hw
hw/srtDivPkg.sv
hw/quotSelect.sv
hw/otfConvert.sv
hw/operandPrep.sv
hw/srtIterate.sv
hw/resultPack.sv
hw/srtDivTop.sv
verif/srtDivTb.sv

//--- run.sh
#!/bin/sh
# builds the divider testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f project.f --top-module srtDivTb
status=0
out=$(./obj_dir/VsrtDivTb 2>&1) || status=$?
echo "$out"
if echo "$out" | grep -q "^NO ERRORS$"; then
  exit 0
fi
echo "simulation failed with status $status"
exit 1
